/* Bender.yml */
package:
  name: qspi_read

sources:
  - include_dirs:
      - source
    files:
      - source/qspi_cmd_pkg.sv
      - source/qspi_data_pkg.sv
      - source/qspi_lane_shifter.sv
      - source/qspi_read_engine.sv
      - source/byte_fifo.sv
      - source/read_drain.sv
      - source/qspi_read_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/flash_model.sv
      - bench/tb_qspi_read.sv

/* all.f */
+incdir+source
source/qspi_cmd_pkg.sv
source/qspi_data_pkg.sv
source/qspi_lane_shifter.sv
source/qspi_read_engine.sv
source/byte_fifo.sv
source/read_drain.sv
source/qspi_read_top.sv
bench/flash_model.sv
bench/tb_qspi_read.sv

/* bench/flash_model.sv */
`include "qspi_consts.svh"

module flash_model (
    input  logic        spi_clk,
    input  logic        cs_n,
    inout  wire  [3:0]  io,
    output logic [7:0]  seen_opcode,
    output logic [31:0] seen_addr
);
    logic [39:0] cmd_shift = '0;
    logic [3:0]  drive_val = 4'b0000;
    logic [3:0]  drive_en = 4'b0000;
    logic [3:0]  chunk;
    int          edge_cnt = 0;
    int          lane_w = 1;
    int          data_start = 40;

    for (genvar i = 0; i < 4; i++)
    begin : g_io
        assign io[i] = drive_en[i] ? drive_val[i] : 1'bz;
    end

    // Byte i holds the low address byte plus i and goes out MSB first
    function automatic logic [3:0] chunk_at(input int k);
        int         per_byte;
        int         pos;
        logic [7:0] value;
        per_byte = 8 / lane_w;
        pos      = k % per_byte;
        value    = seen_addr[7:0] + 8'(k / per_byte);
        return 4'((value >> (8 - lane_w * (pos + 1))) & ((1 << lane_w) - 1));
    endfunction

    // Opcode then address arrive on io0 at the rising edge
    always @(posedge spi_clk or posedge cs_n)
    begin
        if (cs_n)
        begin
            edge_cnt = 0;
            drive_en = 4'b0000;
        end
        else
        begin
            if (edge_cnt < 40)
                cmd_shift = {cmd_shift[38:0], io[0]};
            if (edge_cnt == 7)
            begin
                seen_opcode = cmd_shift[7:0];
                case (cmd_shift[7:0])
                    `QSPI_OP_DUAL:
                    begin
                        lane_w     = 2;
                        data_start = 48;
                    end
                    `QSPI_OP_QUAD:
                    begin
                        lane_w     = 4;
                        data_start = 48;
                    end
                    default:
                    begin
                        lane_w     = 1;
                        data_start = 40;
                    end
                endcase
            end
            if (edge_cnt == 39)
                seen_addr = cmd_shift[31:0];
            edge_cnt++;
        end
    end

    // Data goes out on the falling edge after the dummy byte in wide modes
    always @(negedge spi_clk)
    begin
        if (!cs_n && edge_cnt >= data_start)
        begin
            chunk = chunk_at(edge_cnt - data_start);
            case (lane_w)
                1:
                begin
                    drive_en  = 4'b0010;
                    drive_val = {2'b00, chunk[0], 1'b0};
                end
                2:
                begin
                    drive_en  = 4'b0011;
                    drive_val = {2'b00, chunk[1:0]};
                end
                default:
                begin
                    drive_en  = 4'b1111;
                    drive_val = chunk;
                end
            endcase
        end
    end

endmodule

/* bench/tb_qspi_read.sv */
`include "qspi_consts.svh"

module tb_qspi_read;
    import qspi_cmd_pkg::*;

    // Worst case is a 256 byte standard read plus command and quiet time
    localparam int READ_CYCLES_MAX = 256 * 8 * `QSPI_CLK_DIV + 48 * `QSPI_CLK_DIV + 400;
    localparam int NUM_READS = 7;
    localparam int TIMEOUT_CYCLES = NUM_READS * READ_CYCLES_MAX + 1000;

    logic        system_clk = 1'b0;
    logic        system_reset_n;
    logic        start;
    rd_request_t request;
    logic        spi_clk;
    logic        cs_n;
    wire  [3:0]  io;
    logic        data_valid;
    logic [7:0]  data;
    logic        read_done;
    logic [7:0]  seen_opcode;
    logic [31:0] seen_addr;

    logic [7:0]  rx_q[$];
    int          done_count = 0;
    int          rx_at_done = 0;
    int          cs_fall_count = 0;
    logic        cs_n_prev = 1'b1;
    int          cycle_count = 0;
    integer      seed = 72468;
    int          byte_errors = 0;
    int          opcode_errors = 0;
    int          addr_errors = 0;
    int          count_errors = 0;
    int          level_errors = 0;

    always #2 system_clk = ~system_clk;

    qspi_read_top dut_i (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .start          (start),
        .request        (request),
        .spi_clk        (spi_clk),
        .cs_n           (cs_n),
        .io             (io),
        .data_valid     (data_valid),
        .data           (data),
        .read_done      (read_done)
    );

    flash_model flash_i (
        .spi_clk     (spi_clk),
        .cs_n        (cs_n),
        .io          (io),
        .seen_opcode (seen_opcode),
        .seen_addr   (seen_addr)
    );

    // Outputs settle after the rising edge, so watch them on the falling one
    always @(negedge system_clk)
    begin
        if (data_valid)
            rx_q.push_back(data);
        if (read_done)
        begin
            done_count++;
            rx_at_done = rx_q.size();
        end
        if (cs_n_prev && !cs_n)
            cs_fall_count++;
        cs_n_prev = cs_n;
    end

    always @(posedge system_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the reads did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            byte_errors++;
        end
    endtask

    task automatic check_mode_opcode(input read_mode_t mode, input logic [7:0] got);
        logic [7:0] exp;
        case (mode)
            MODE_DUAL: exp = 8'h3C;
            MODE_QUAD: exp = 8'h6C;
            default:   exp = 8'h13;
        endcase
        if (got !== exp)
        begin
            $display("ERROR flash opcode: got 0x%h, expected 0x%h", got, exp);
            opcode_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            count_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            level_errors++;
        end
    endtask

    task automatic clear_monitor();
        rx_q.delete();
        done_count    = 0;
        rx_at_done    = 0;
        cs_fall_count = 0;
    endtask

    task automatic send_request(input read_mode_t mode, input logic [31:0] addr, input int count);
        rd_request_t req;
        req.mode       = mode;
        req.addr       = addr;
        req.byte_count = count[`QSPI_COUNT_W-1:0];
        @(posedge system_clk);
        request <= req;
        start   <= 1'b1;
        @(posedge system_clk);
        start <= 1'b0;
    endtask

    task automatic wait_read_done();
        while (done_count == 0)
            @(posedge system_clk);
    endtask

    task automatic verify_result(input read_mode_t mode, input logic [31:0] addr, input int count,
                                 input int quiet_cycles);
        int n;
        repeat (quiet_cycles) @(posedge system_clk);
        check_count("read_done pulses", done_count, 1);
        check_count("data_valid before read_done", rx_at_done, count);
        check_count("data_valid pulses", rx_q.size(), count);
        check_count("cs_n falls", cs_fall_count, 1);
        check_level("cs_n", cs_n, 1'b1);
        check_mode_opcode(mode, seen_opcode);
        check_addr("flash address", seen_addr, addr);
        n = (rx_q.size() < count) ? rx_q.size() : count;
        for (int i = 0; i < n; i++)
            check_byte($sformatf("data[%0d]", i), rx_q[i], addr[7:0] + 8'(i));
    endtask

    task automatic read_and_verify(input read_mode_t mode, input logic [31:0] addr, input int count);
        clear_monitor();
        send_request(mode, addr, count);
        wait_read_done();
        verify_result(mode, addr, count, 16);
    endtask

    task automatic idle_after_reset();
        repeat (8) @(posedge system_clk);
        check_level("cs_n", cs_n, 1'b1);
        check_level("spi_clk", spi_clk, 1'b0);
        check_count("data_valid pulses", rx_q.size(), 0);
        check_count("read_done pulses", done_count, 0);
    endtask

    task automatic standard_read();
        logic [31:0] addr;
        int          count;
        addr  = $random(seed);
        count = ($random(seed) & 255) + 1;
        read_and_verify(MODE_STANDARD, addr, count);
    endtask

    task automatic dual_and_quad_reads();
        logic [31:0] addr;
        int          count;
        addr  = $random(seed);
        count = ($random(seed) & 255) + 1;
        read_and_verify(MODE_DUAL, addr, count);
        addr  = $random(seed);
        count = ($random(seed) & 255) + 1;
        read_and_verify(MODE_QUAD, addr, count);
    endtask

    task automatic count_extremes();
        read_and_verify(MODE_QUAD, $random(seed), 1);
        read_and_verify(MODE_DUAL, $random(seed), 5);
        read_and_verify(MODE_STANDARD, $random(seed), 256);
    endtask

    // Extra starts during command and data must not disturb the read
    task automatic busy_start_ignored();
        logic [31:0] addr;
        addr = $random(seed);
        clear_monitor();
        send_request(MODE_STANDARD, addr, 12);
        repeat (10) @(posedge system_clk);
        send_request(MODE_QUAD, ~addr, 3);
        while (rx_q.size() == 0)
            @(posedge system_clk);
        send_request(MODE_DUAL, addr + 32'h100, 7);
        wait_read_done();
        verify_result(MODE_STANDARD, addr, 12, 300);
    endtask

    initial
    begin
        start          = 1'b0;
        request        = '0;
        system_reset_n = 1'b0;
        repeat (3) @(posedge system_clk);
        system_reset_n <= 1'b1;
        idle_after_reset();
        standard_read();
        dual_and_quad_reads();
        count_extremes();
        busy_start_ignored();
        $display("Errors: byte %0d, opcode %0d, address %0d, count %0d, level %0d",
                 byte_errors, opcode_errors, addr_errors, count_errors, level_errors);
        if (byte_errors + opcode_errors + addr_errors + count_errors + level_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* source/byte_fifo.sv */
module byte_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  system_clk,
    input  logic  system_reset_n,
    input  logic  write,
    input  logic  pop,
    input  item_t write_item,
    output item_t head_item,
    output logic  empty
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop_ok;

    assign pop_ok    = pop && !empty;
    assign empty     = (count == '0);
    assign head_item = mem[rd_ptr];

    always_ff @(posedge system_clk)
    begin
        if (write)
        begin
            mem[wr_ptr] <= write_item;
        end
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (write)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            // Simultaneous write and pop leaves the level unchanged
            case ({write, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/qspi_cmd_pkg.sv */
`include "qspi_consts.svh"

package qspi_cmd_pkg;

    // Code 3 is unused and falls back to standard
    typedef enum logic [1:0]
    {
        MODE_STANDARD = 2'd0,
        MODE_DUAL     = 2'd1,
        MODE_QUAD     = 2'd2
    } read_mode_t;

    typedef struct packed
    {
        read_mode_t               mode;
        logic [31:0]              addr;
        // Data bytes only
        logic [`QSPI_COUNT_W-1:0] byte_count;
    } rd_request_t;

endpackage

/* source/qspi_consts.svh */
`ifndef QSPI_CONSTS_SVH
`define QSPI_CONSTS_SVH

// Read opcodes
`define QSPI_OP_STANDARD 8'h13
`define QSPI_OP_DUAL     8'h3C
`define QSPI_OP_QUAD     8'h6C

// Address sent as four bytes with the MSB first
`define QSPI_ADDR_BYTES 4

// System clocks per SPI clock
`define QSPI_CLK_DIV 4

// Receive buffer
`define QSPI_FIFO_DEPTH 256

// Byte count field holding 1 to 256
`define QSPI_COUNT_W 9

`endif

/* source/qspi_data_pkg.sv */
package qspi_data_pkg;

    typedef struct packed
    {
        logic [7:0] data;
        // Final byte of the read
        logic       last;
    } rd_beat_t;

endpackage

/* source/qspi_lane_shifter.sv */
module qspi_lane_shifter (
    input  logic                     system_clk,
    input  logic                     system_reset_n,
    input  logic                     sample,
    input  qspi_cmd_pkg::read_mode_t mode,
    input  logic [3:0]               lanes,
    output logic                     byte_ready,
    output logic [7:0]               byte_data
);
    import qspi_cmd_pkg::*;

    logic [7:0] shift_q;
    logic [7:0] shift_next;
    logic [2:0] lane_cnt;
    logic [2:0] last_cnt;

    // io1 is the upper bit in dual mode, io3 in quad mode
    always_comb
    begin
        case (mode)
            MODE_DUAL:
            begin
                shift_next = {shift_q[5:0], lanes[1:0]};
                last_cnt   = 3'd3;
            end
            MODE_QUAD:
            begin
                shift_next = {shift_q[3:0], lanes};
                last_cnt   = 3'd1;
            end
            default:
            begin
                shift_next = {shift_q[6:0], lanes[1]};
                last_cnt   = 3'd7;
            end
        endcase
    end

    always_ff @(posedge system_clk)
    begin
        if (sample)
        begin
            shift_q <= shift_next;
        end
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            lane_cnt   <= 3'd0;
            byte_ready <= 1'b0;
        end
        else
        begin
            byte_ready <= 1'b0;
            if (sample)
            begin
                if (lane_cnt == last_cnt)
                begin
                    lane_cnt   <= 3'd0;
                    byte_ready <= 1'b1;
                end
                else
                begin
                    lane_cnt <= lane_cnt + 3'd1;
                end
            end
        end
    end

    // Shift register holds the full byte while byte_ready is high
    assign byte_data = shift_q;

endmodule

/* source/qspi_read_engine.sv */
`include "qspi_consts.svh"

module qspi_read_engine (
    input  logic                      system_clk,
    input  logic                      system_reset_n,
    input  logic                      start,
    input  qspi_cmd_pkg::rd_request_t request,
    output logic                      spi_clk,
    output logic                      cs_n,
    output logic [3:0]                io_out,
    output logic [3:0]                io_oe,
    input  logic [3:0]                io_in,
    output logic                      beat_write,
    output qspi_data_pkg::rd_beat_t   beat
);
    import qspi_cmd_pkg::*;

    localparam int PHASE_W  = $clog2(`QSPI_CLK_DIV);
    localparam int CMD_BITS = 8 * (1 + `QSPI_ADDR_BYTES);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`QSPI_CLK_DIV - 1);
    localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(`QSPI_CLK_DIV / 2);

    typedef enum logic [2:0] {IDLE, COMMAND, DUMMY, DATA, FINISH} state_t;

    state_t                   state;
    state_t                   next_state;
    rd_request_t              req_q;
    logic [PHASE_W-1:0]       phase;
    logic [PHASE_W-1:0]       phase_next;
    logic [5:0]               bit_cnt;
    logic [`QSPI_COUNT_W-1:0] rx_count;
    logic [7:0]               opcode;
    logic [CMD_BITS-1:0]      cmd_word;
    logic                     wide_mode;
    logic                     spi_end;
    logic                     sample;
    logic                     byte_ready;
    logic [7:0]               byte_data;
    logic                     last_byte;

    always_comb
    begin
        case (req_q.mode)
            MODE_DUAL: opcode = `QSPI_OP_DUAL;
            MODE_QUAD: opcode = `QSPI_OP_QUAD;
            default:   opcode = `QSPI_OP_STANDARD;
        endcase
    end

    assign cmd_word  = {opcode, req_q.addr};
    assign wide_mode = (req_q.mode == MODE_DUAL) || (req_q.mode == MODE_QUAD);
    assign spi_end   = (phase == PHASE_LAST);
    // Sample at the end of the first high cycle
    assign sample    = (state == DATA) && (phase == PHASE_HIGH);
    assign last_byte = (rx_count == req_q.byte_count - 1'b1);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (start)
                    next_state = COMMAND;
            COMMAND:
                if (spi_end && bit_cnt == 6'(CMD_BITS - 1))
                    next_state = wide_mode ? DUMMY : DATA;
            DUMMY:
                if (spi_end && bit_cnt == 6'd7)
                    next_state = DATA;
            DATA:
                if (byte_ready && last_byte)
                    next_state = FINISH;
            default:
                next_state = IDLE;
        endcase
    end

    always_comb
    begin
        phase_next = '0;
        if (state inside {COMMAND, DUMMY, DATA} && !spi_end)
        begin
            phase_next = phase + 1'b1;
        end
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            state    <= IDLE;
            phase    <= '0;
            bit_cnt  <= 6'd0;
            rx_count <= '0;
            cs_n     <= 1'b1;
            spi_clk  <= 1'b0;
        end
        else
        begin
            state   <= next_state;
            phase   <= phase_next;
            spi_clk <= (next_state inside {COMMAND, DUMMY, DATA}) && (phase_next >= PHASE_HIGH);
            if (next_state != state)
                bit_cnt <= 6'd0;
            else if (spi_end)
                bit_cnt <= bit_cnt + 6'd1;
            if (state == IDLE)
                rx_count <= '0;
            else if (byte_ready)
                rx_count <= rx_count + 1'b1;
            if (state == IDLE && start)
                cs_n <= 1'b0;
            else if (state == FINISH)
                cs_n <= 1'b1;
        end
    end

    always_ff @(posedge system_clk)
    begin
        if (state == IDLE && start)
        begin
            req_q <= request;
        end
    end

    // io0 carries opcode and address and idles low
    // Wide reads keep every lane released until cs_n rises
    always_comb
    begin
        io_out = 4'b0000;
        io_oe  = 4'b0001;
        if (state == COMMAND)
            io_out[0] = cmd_word[CMD_BITS - 1 - bit_cnt];
        else if (state inside {DATA, FINISH} && wide_mode)
            io_oe = 4'b0000;
    end

    qspi_lane_shifter shifter_i (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .sample         (sample),
        .mode           (req_q.mode),
        .lanes          (io_in),
        .byte_ready     (byte_ready),
        .byte_data      (byte_data)
    );

    always_comb
    begin
        beat_write = byte_ready && (state == DATA);
        beat.data  = byte_data;
        beat.last  = last_byte;
    end

endmodule

/* source/qspi_read_top.sv */
`include "qspi_consts.svh"

module qspi_read_top (
    input  logic                      system_clk,
    input  logic                      system_reset_n,
    input  logic                      start,
    input  qspi_cmd_pkg::rd_request_t request,
    output logic                      spi_clk,
    output logic                      cs_n,
    inout  wire  [3:0]                io,
    output logic                      data_valid,
    output logic [7:0]                data,
    output logic                      read_done
);
    import qspi_data_pkg::*;

    logic [3:0] io_out;
    logic [3:0] io_oe;
    logic [3:0] io_in;
    logic       beat_write;
    logic       fifo_empty;
    logic       fifo_pop;
    rd_beat_t   beat;
    rd_beat_t   head_item;

    // Tristate per lane
    for (genvar i = 0; i < 4; i++)
    begin : g_io
        assign io[i] = io_oe[i] ? io_out[i] : 1'bz;
    end

    assign io_in = io;

    qspi_read_engine engine_i (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .start          (start),
        .request        (request),
        .spi_clk        (spi_clk),
        .cs_n           (cs_n),
        .io_out         (io_out),
        .io_oe          (io_oe),
        .io_in          (io_in),
        .beat_write     (beat_write),
        .beat           (beat)
    );

    byte_fifo #(
        .item_t (rd_beat_t),
        .DEPTH  (`QSPI_FIFO_DEPTH)
    ) fifo_i (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .write          (beat_write),
        .pop            (fifo_pop),
        .write_item     (beat),
        .head_item      (head_item),
        .empty          (fifo_empty)
    );

    read_drain drain_i (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .empty          (fifo_empty),
        .head_item      (head_item),
        .pop            (fifo_pop),
        .data_valid     (data_valid),
        .data           (data),
        .read_done      (read_done)
    );

endmodule

/* source/read_drain.sv */
module read_drain (
    input  logic                    system_clk,
    input  logic                    system_reset_n,
    input  logic                    empty,
    input  qspi_data_pkg::rd_beat_t head_item,
    output logic                    pop,
    output logic                    data_valid,
    output logic [7:0]              data,
    output logic                    read_done
);
    logic last_pending;

    // data_valid high means a pop went out on the previous cycle
    assign pop = !empty && !data_valid;

    always_ff @(posedge system_clk)
    begin
        if (pop)
        begin
            data <= head_item.data;
        end
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            data_valid   <= 1'b0;
            last_pending <= 1'b0;
            read_done    <= 1'b0;
        end
        else
        begin
            data_valid   <= pop;
            last_pending <= pop && head_item.last;
            read_done    <= last_pending;
        end
    end

endmodule
